// ==== common/tcdm_config.svh ====
/* Build-time sizes of the TCDM sub-group.
   Bank and port counts must stay powers of two; data width a multiple of 8. */

`ifndef TCDM_CONFIG_SVH
`define TCDM_CONFIG_SVH

// ------------------------------------------------------------
// Topology
// ------------------------------------------------------------

// Core request ports, the DMA comes on top
`define TCDM_NUM_PORTS 4

// Word-interleaved banks
`define TCDM_NUM_BANKS 4

// ------------------------------------------------------------
// Bank geometry
// ------------------------------------------------------------

// Rows per bank
`define TCDM_BANK_DEPTH 64

// Bits per word
`define TCDM_DATA_W 32

`endif

// ==== common/tcdm_pkg.sv ====
/* Shared types of the TCDM sub-group, sized from tcdm_config.svh.
   Word addresses only; the low address bits select the bank. */

`include "tcdm_config.svh"

package tcdm_pkg;

  // Four cores plus the DMA
  localparam int unsigned num_initiators = `TCDM_NUM_PORTS + 1;

  localparam int unsigned ini_idx_w  = $clog2(num_initiators);
  localparam int unsigned bank_idx_w = $clog2(`TCDM_NUM_BANKS);
  localparam int unsigned row_w      = $clog2(`TCDM_BANK_DEPTH);
  localparam int unsigned addr_w     = bank_idx_w + row_w;
  localparam int unsigned strb_w     = `TCDM_DATA_W / 8;

  typedef logic [addr_w-1:0]      tcdm_addr_t;
  typedef logic [bank_idx_w-1:0]  bank_idx_t;
  typedef logic [row_w-1:0]       row_addr_t;
  typedef logic [ini_idx_w-1:0]   ini_idx_t;
  typedef logic [`TCDM_DATA_W-1:0] tcdm_data_t;
  typedef logic [strb_w-1:0]      tcdm_strb_t;

  typedef struct packed {
    tcdm_addr_t tgt_addr;
    logic       wen;
    tcdm_data_t wdata;
    tcdm_strb_t be;
  } tcdm_req_t;

  typedef struct packed {
    row_addr_t  row;
    ini_idx_t   ini;
    logic       wen;
    tcdm_data_t wdata;
    tcdm_strb_t be;
  } bank_req_t;

  typedef struct packed {
    ini_idx_t   ini;
    tcdm_data_t rdata;
  } bank_resp_t;

  typedef enum logic [2:0] {
    IDLE,
    READ,
    READ_WAIT,
    WRITE,
    WRITE_WAIT
  } dma_state_e;

endpackage

// ==== dma/dma_beat_counter.sv ====
/* Remaining-beat counter and word offset of the DMA.
   Lengths up to 127 words. */

module dma_beat_counter (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 load_i,
  input  logic [6:0]           len_i,
  input  logic                 step_i,
  output tcdm_pkg::tcdm_addr_t offset_o,
  output logic                 last_o,
  output logic                 zero_o
);

  import tcdm_pkg::*;

  logic [6:0] remaining_q;
  tcdm_addr_t offset_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      remaining_q <= '0;
      offset_q    <= '0;
    end else if (load_i) begin
      remaining_q <= len_i;
      offset_q    <= '0;
    end else if (step_i) begin
      remaining_q <= remaining_q - 1'b1;
      offset_q    <= offset_q + 1'b1;
    end
  end

  assign offset_o = offset_q;
  assign last_o   = (remaining_q == 7'd1);
  assign zero_o   = (remaining_q == '0);

endmodule

// ==== dma/dma_ctrl_fsm.sv ====
/* Word copy engine; one read then one write per beat, each waiting for its response.
   Source and destination are word addresses and wrap at the end of the TCDM. */

module dma_ctrl_fsm (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 dma_valid_i,
  output logic                 dma_ready_o,
  input  tcdm_pkg::tcdm_addr_t dma_src_i,
  input  tcdm_pkg::tcdm_addr_t dma_dst_i,
  input  logic                 beat_last_i,
  input  logic                 beat_zero_i,
  input  tcdm_pkg::tcdm_addr_t beat_offset_i,
  output logic                 beat_load_o,
  output logic                 beat_step_o,
  output logic                 mem_req_valid_o,
  input  logic                 mem_req_ready_i,
  output tcdm_pkg::tcdm_req_t  mem_req_o,
  input  logic                 mem_resp_valid_i,
  output logic                 mem_resp_ready_o,
  input  tcdm_pkg::tcdm_data_t mem_resp_rdata_i,
  output logic                 idle_o,
  output logic                 done_o
);

  import tcdm_pkg::*;

  dma_state_e state_q, state_d;
  logic       done_q, done_d;
  tcdm_addr_t src_q;
  tcdm_addr_t dst_q;
  tcdm_data_t rdata_q;

  assign beat_load_o = (state_q == IDLE) && dma_valid_i;

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------

  always_comb begin
    state_d          = state_q;
    done_d           = 1'b0;
    mem_req_valid_o  = 1'b0;
    mem_resp_ready_o = 1'b0;
    beat_step_o      = 1'b0;
    case (state_q)
      IDLE: begin
        if (dma_valid_i) begin
          state_d = READ;
        end
      end
      READ: begin
        // Zero length finishes without touching memory
        if (beat_zero_i) begin
          done_d  = 1'b1;
          state_d = IDLE;
        end else begin
          mem_req_valid_o = 1'b1;
          if (mem_req_ready_i) begin
            state_d = READ_WAIT;
          end
        end
      end
      READ_WAIT: begin
        mem_resp_ready_o = 1'b1;
        if (mem_resp_valid_i) begin
          state_d = WRITE;
        end
      end
      WRITE: begin
        mem_req_valid_o = 1'b1;
        if (mem_req_ready_i) begin
          state_d = WRITE_WAIT;
        end
      end
      WRITE_WAIT: begin
        mem_resp_ready_o = 1'b1;
        if (mem_resp_valid_i) begin
          beat_step_o = 1'b1;
          done_d      = beat_last_i;
          state_d     = beat_last_i ? IDLE : READ;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    mem_req_o.tgt_addr = (state_q == WRITE) ? dst_q + beat_offset_i : src_q + beat_offset_i;
    mem_req_o.wen      = (state_q == WRITE);
    mem_req_o.wdata    = rdata_q;
    mem_req_o.be       = '1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_load_o) begin
      src_q <= dma_src_i;
      dst_q <= dma_dst_i;
    end
    if (state_q == READ_WAIT && mem_resp_valid_i) begin
      rdata_q <= mem_resp_rdata_i;
    end
  end

  assign dma_ready_o = (state_q == IDLE);
  assign idle_o      = (state_q == IDLE);
  assign done_o      = done_q;

endmodule

// ==== interco/stream_spill_reg.sv ====
/* One-entry valid/ready register; output is always registered.
   Full throughput when the sink takes every cycle. */

module stream_spill_reg #(
  parameter type data_t = logic
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  data_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output data_t data_o
);

  logic  valid_q;
  data_t data_q;

  // Accept when empty or being drained this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// ==== interco/tcdm_bank.sv ====
/* Single-port word bank, byte-enabled writes, one cycle read latency.
   Every request gets a response; writes answer with zero data. */

`include "tcdm_config.svh"

module tcdm_bank (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  input  tcdm_pkg::bank_req_t  req_i,
  output logic                 resp_valid_o,
  input  logic                 resp_ready_i,
  output tcdm_pkg::bank_resp_t resp_o
);

  import tcdm_pkg::*;

  tcdm_data_t mem_q [`TCDM_BANK_DEPTH];
  logic       valid_q;
  bank_resp_t resp_q;
  logic       req_fire;

  // Stall while the result is not taken
  assign req_ready_o = !valid_q || resp_ready_i;
  assign req_fire    = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.ini   <= req_i.ini;
      resp_q.rdata <= req_i.wen ? '0 : mem_q[req_i.row];
      if (req_i.wen) begin
        for (int j = 0; j < strb_w; j++) begin
          if (req_i.be[j]) begin
            mem_q[req_i.row][8*j +: 8] <= req_i.wdata[8*j +: 8];
          end
        end
      end
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_o       = resp_q;

endmodule

// ==== interco/tcdm_local_interco.sv ====
/* Routes initiator word requests to the banks and the responses back.
   Each initiator may have one request in flight; ready stays low until its response. */

`include "tcdm_config.svh"

module tcdm_local_interco (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic                 [tcdm_pkg::num_initiators-1:0] ini_req_valid_i,
  output logic                 [tcdm_pkg::num_initiators-1:0] ini_req_ready_o,
  input  tcdm_pkg::tcdm_req_t  [tcdm_pkg::num_initiators-1:0] ini_req_i,
  output logic                 [tcdm_pkg::num_initiators-1:0] ini_resp_valid_o,
  input  logic                 [tcdm_pkg::num_initiators-1:0] ini_resp_ready_i,
  output tcdm_pkg::tcdm_data_t [tcdm_pkg::num_initiators-1:0] ini_resp_rdata_o
);

  import tcdm_pkg::*;

  localparam int unsigned num_banks = `TCDM_NUM_BANKS;

  bank_idx_t  [num_initiators-1:0] ini_bank;
  logic       [num_initiators-1:0] outstanding_q;

  logic       [num_banks-1:0] arb_valid;
  logic       [num_banks-1:0] arb_ready;
  bank_req_t  [num_banks-1:0] arb_req;
  ini_idx_t   [num_banks-1:0] gnt_idx;
  ini_idx_t   [num_banks-1:0] rr_q;

  logic       [num_banks-1:0] rsp_valid;
  logic       [num_banks-1:0] rsp_ready;
  bank_resp_t [num_banks-1:0] rsp;

  for (genvar i = 0; i < num_initiators; i++) begin : gen_bank_sel
    assign ini_bank[i] = ini_req_i[i].tgt_addr[bank_idx_w-1:0];
  end

  // ------------------------------------------------------------
  // Per-bank round-robin arbitration
  // ------------------------------------------------------------

  always_comb begin
    int   idx;
    logic found;
    arb_valid = '0;
    arb_req   = '0;
    gnt_idx   = '0;
    for (int b = 0; b < num_banks; b++) begin
      found = 1'b0;
      // Search starts at the pointer and wraps
      for (int k = 0; k < num_initiators; k++) begin
        idx = int'(rr_q[b]) + k;
        if (idx >= num_initiators) begin
          idx = idx - num_initiators;
        end
        if (!found && ini_req_valid_i[idx] && !outstanding_q[idx] &&
            ini_bank[idx] == bank_idx_t'(b)) begin
          found      = 1'b1;
          gnt_idx[b] = ini_idx_t'(idx);
        end
      end
      arb_valid[b]     = found;
      arb_req[b].row   = ini_req_i[gnt_idx[b]].tgt_addr[addr_w-1:bank_idx_w];
      arb_req[b].ini   = gnt_idx[b];
      arb_req[b].wen   = ini_req_i[gnt_idx[b]].wen;
      arb_req[b].wdata = ini_req_i[gnt_idx[b]].wdata;
      arb_req[b].be    = ini_req_i[gnt_idx[b]].be;
    end
  end

  always_comb begin
    ini_req_ready_o = '0;
    for (int i = 0; i < num_initiators; i++) begin
      ini_req_ready_o[i] = !outstanding_q[i] && arb_valid[ini_bank[i]] &&
                           arb_ready[ini_bank[i]] && gnt_idx[ini_bank[i]] == ini_idx_t'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else begin
      for (int b = 0; b < num_banks; b++) begin
        if (arb_valid[b] && arb_ready[b]) begin
          rr_q[b] <= (gnt_idx[b] == ini_idx_t'(num_initiators - 1)) ? '0 : gnt_idx[b] + 1'b1;
        end
      end
    end
  end

  // One request in flight per initiator
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= (outstanding_q | (ini_req_valid_i & ini_req_ready_o)) &
                       ~(ini_resp_valid_o & ini_resp_ready_i);
    end
  end

  // ------------------------------------------------------------
  // Banks with request and response registers
  // ------------------------------------------------------------

  for (genvar b = 0; b < num_banks; b++) begin : gen_banks
    logic       bank_in_valid;
    logic       bank_in_ready;
    bank_req_t  bank_in;
    logic       bank_out_valid;
    logic       bank_out_ready;
    bank_resp_t bank_out;

    stream_spill_reg #(
      .data_t(bank_req_t)
    ) i_req_reg (
      .clk_i  (clk_i        ),
      .rst_i  (rst_i        ),
      .valid_i(arb_valid[b] ),
      .ready_o(arb_ready[b] ),
      .data_i (arb_req[b]   ),
      .valid_o(bank_in_valid),
      .ready_i(bank_in_ready),
      .data_o (bank_in      )
    );

    tcdm_bank i_bank (
      .clk_i       (clk_i         ),
      .rst_i       (rst_i         ),
      .req_valid_i (bank_in_valid ),
      .req_ready_o (bank_in_ready ),
      .req_i       (bank_in       ),
      .resp_valid_o(bank_out_valid),
      .resp_ready_i(bank_out_ready),
      .resp_o      (bank_out      )
    );

    stream_spill_reg #(
      .data_t(bank_resp_t)
    ) i_resp_reg (
      .clk_i  (clk_i         ),
      .rst_i  (rst_i         ),
      .valid_i(bank_out_valid),
      .ready_o(bank_out_ready),
      .data_i (bank_out      ),
      .valid_o(rsp_valid[b]  ),
      .ready_i(rsp_ready[b]  ),
      .data_o (rsp[b]        )
    );
  end

  // Response return by initiator index, never two banks for one initiator
  always_comb begin
    ini_resp_valid_o = '0;
    ini_resp_rdata_o = '0;
    rsp_ready        = '0;
    for (int b = 0; b < num_banks; b++) begin
      if (rsp_valid[b]) begin
        ini_resp_valid_o[rsp[b].ini] = 1'b1;
        ini_resp_rdata_o[rsp[b].ini] = rsp[b].rdata;
        rsp_ready[b]                 = ini_resp_ready_i[rsp[b].ini];
      end
    end
  end

endmodule

// ==== project.f ====
+incdir+common
common/tcdm_pkg.sv
interco/stream_spill_reg.sv
interco/tcdm_bank.sv
interco/tcdm_local_interco.sv
dma/dma_beat_counter.sv
dma/dma_ctrl_fsm.sv
src/tcdm_sub_group.sv
sim/tb_tcdm_sub_group.sv

// ==== run.sh ====
#!/bin/sh
# Builds the TCDM sub-group testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_tcdm_sub_group \
  -Mdir build -o sim_tcdm

./build/sim_tcdm > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "TESTS PASSED" sim.log

// ==== sim/tb_tcdm_sub_group.sv ====
/* Testbench for the TCDM sub-group. Reads only target words written earlier.
   Entries marked parallel are issued at once, one port each, on distinct addresses. */

`include "tcdm_config.svh"

module tb_tcdm_sub_group;
  timeunit 1ns;
  timeprecision 100ps;

  import tcdm_pkg::*;

  localparam int num_ports   = `TCDM_NUM_PORTS;
  localparam int num_entries = 22;

  typedef struct {
    int         port;
    logic       wen;
    tcdm_addr_t addr;
    tcdm_data_t data;
    tcdm_strb_t be;
    logic       dma;
    tcdm_addr_t dst;
    logic [6:0] len;
    logic       par;
  } entry_t;

  logic                            clk;
  logic                            rst_i;
  logic       [num_ports-1:0]      core_req_valid_i;
  logic       [num_ports-1:0]      core_req_ready_o;
  tcdm_req_t  [num_ports-1:0]      core_req_i;
  logic       [num_ports-1:0]      core_resp_valid_o;
  logic       [num_ports-1:0]      core_resp_ready_i;
  tcdm_data_t [num_ports-1:0]      core_resp_rdata_o;
  logic                            dma_valid_i;
  logic                            dma_ready_o;
  tcdm_addr_t                      dma_src_i;
  tcdm_addr_t                      dma_dst_i;
  logic       [6:0]                dma_len_i;
  logic                            dma_idle_o;
  logic                            dma_done_o;

  entry_t     tbl [num_entries];
  tcdm_data_t ref_mem [256];
  logic       [num_ports-1:0] pending;
  int         data_errors;
  int         flag_errors;

  tcdm_sub_group DUT (
    .clk_i            (clk              ),
    .rst_i            (rst_i            ),
    .core_req_valid_i (core_req_valid_i ),
    .core_req_ready_o (core_req_ready_o ),
    .core_req_i       (core_req_i       ),
    .core_resp_valid_o(core_resp_valid_o),
    .core_resp_ready_i(core_resp_ready_i),
    .core_resp_rdata_o(core_resp_rdata_o),
    .dma_valid_i      (dma_valid_i      ),
    .dma_ready_o      (dma_ready_o      ),
    .dma_src_i        (dma_src_i        ),
    .dma_dst_i        (dma_dst_i        ),
    .dma_len_i        (dma_len_i        ),
    .dma_idle_o       (dma_idle_o       ),
    .dma_done_o       (dma_done_o       )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Checks and reference model
  // ------------------------------------------------------------

  task automatic check_data(input string name, input tcdm_pkg::tcdm_data_t expected,
                            input tcdm_pkg::tcdm_data_t actual);
    if (actual !== expected) begin
      data_errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  function automatic void apply_write(input tcdm_addr_t a, input tcdm_data_t d,
                                      input tcdm_strb_t be);
    for (int j = 0; j < strb_w; j++) begin
      if (be[j]) begin
        ref_mem[a][8*j +: 8] = d[8*j +: 8];
      end
    end
  endfunction

  task automatic add_access(input int idx, input int port, input logic wen, input tcdm_addr_t a,
                            input tcdm_data_t d, input tcdm_strb_t be, input logic par);
    tbl[idx] = '{port, wen, a, d, be, 1'b0, 8'h00, 7'd0, par};
  endtask

  task automatic add_copy(input int idx, input tcdm_addr_t src, input tcdm_addr_t dst,
                          input logic [6:0] len);
    tbl[idx] = '{0, 1'b0, src, 32'h0, 4'h0, 1'b1, dst, len, 1'b0};
  endtask

  task automatic load_table();
    add_access(0, 0, 1'b1, 8'h04, 32'h11223344, 4'hf, 1'b0);
    // Partial write merges into the full word above
    add_access(1, 0, 1'b1, 8'h04, 32'haabbccdd, 4'h5, 1'b0);
    add_access(2, 0, 1'b0, 8'h04, 32'h0, 4'h0, 1'b0);
    add_access(3, 1, 1'b1, 8'h08, 32'h55667788, 4'hf, 1'b1);
    add_access(4, 2, 1'b1, 8'h0c, 32'h99aabbcc, 4'hf, 1'b1);
    add_access(5, 3, 1'b1, 8'h10, 32'h0f1e2d3c, 4'hf, 1'b0);
    // All four ports on bank 0
    add_access(6, 0, 1'b0, 8'h10, 32'h0, 4'h0, 1'b1);
    add_access(7, 1, 1'b0, 8'h0c, 32'h0, 4'h0, 1'b1);
    add_access(8, 2, 1'b0, 8'h08, 32'h0, 4'h0, 1'b1);
    add_access(9, 3, 1'b0, 8'h04, 32'h0, 4'h0, 1'b0);
    add_access(10, 0, 1'b1, 8'h20, 32'hcafe0001, 4'hf, 1'b1);
    add_access(11, 1, 1'b1, 8'h21, 32'hcafe0102, 4'hf, 1'b1);
    add_access(12, 2, 1'b1, 8'h22, 32'hcafe0203, 4'hf, 1'b1);
    add_access(13, 3, 1'b1, 8'h23, 32'hcafe0304, 4'hf, 1'b0);
    add_copy(14, 8'h20, 8'h40, 7'd4);
    add_access(15, 0, 1'b0, 8'h40, 32'h0, 4'h0, 1'b1);
    add_access(16, 1, 1'b0, 8'h41, 32'h0, 4'h0, 1'b1);
    add_access(17, 2, 1'b0, 8'h42, 32'h0, 4'h0, 1'b1);
    add_access(18, 3, 1'b0, 8'h43, 32'h0, 4'h0, 1'b0);
    add_copy(19, 8'h20, 8'h60, 7'd0);
    add_access(20, 1, 1'b1, 8'h08, 32'hdeadbeef, 4'ha, 1'b0);
    add_access(21, 1, 1'b0, 8'h08, 32'h0, 4'h0, 1'b0);
  endtask

  // ------------------------------------------------------------
  // Drivers entered and left just after a rising edge
  // ------------------------------------------------------------

  task automatic do_access(input int p, input int i);
    tcdm_req_t  req;
    tcdm_data_t expected;
    tcdm_data_t held;
    int         stall;
    string      name;
    string      rdy_name;
    req.tgt_addr = tbl[i].addr;
    req.wen      = tbl[i].wen;
    req.wdata    = tbl[i].data;
    req.be       = tbl[i].be;
    name         = $sformatf("core_resp_rdata_o[%0d]", p);
    rdy_name     = $sformatf("core_req_ready_o[%0d]", p);
    if (tbl[i].wen) begin
      apply_write(tbl[i].addr, tbl[i].data, tbl[i].be);
      expected = '0;
    end else begin
      expected = ref_mem[tbl[i].addr];
    end
    core_req_i[p]       <= req;
    core_req_valid_i[p] <= 1'b1;
    do @(negedge clk); while (!core_req_ready_o[p]);
    @(posedge clk);
    core_req_valid_i[p] <= 1'b0;
    pending[p] = 1'b1;
    // Ready stays low until the response is taken
    do begin
      @(negedge clk);
      check_flag(rdy_name, 1'b0, core_req_ready_o[p]);
    end while (!core_resp_valid_o[p]);
    held  = core_resp_rdata_o[p];
    stall = int'($urandom % 5);
    // Response holds under back-pressure
    repeat (stall) begin
      @(negedge clk);
      check_flag($sformatf("core_resp_valid_o[%0d]", p), 1'b1, core_resp_valid_o[p]);
      check_data(name, held, core_resp_rdata_o[p]);
      check_flag(rdy_name, 1'b0, core_req_ready_o[p]);
    end
    @(posedge clk);
    core_resp_ready_i[p] <= 1'b1;
    @(negedge clk);
    check_flag($sformatf("core_resp_valid_o[%0d]", p), 1'b1, core_resp_valid_o[p]);
    check_data(name, expected, core_resp_rdata_o[p]);
    @(posedge clk);
    core_resp_ready_i[p] <= 1'b0;
    pending[p] = 1'b0;
  endtask

  task automatic run_port(input int p, input int first, input int last);
    for (int i = first; i <= last; i++) begin
      if (tbl[i].port == p) begin
        do_access(p, i);
      end
    end
  endtask

  task automatic run_copy(input int i);
    dma_src_i   <= tbl[i].addr;
    dma_dst_i   <= tbl[i].dst;
    dma_len_i   <= tbl[i].len;
    dma_valid_i <= 1'b1;
    do @(negedge clk); while (!dma_ready_o);
    @(posedge clk);
    dma_valid_i <= 1'b0;
    @(negedge clk);
    // Busy right after the request is taken
    check_flag("dma_idle_o", 1'b0, dma_idle_o);
    while (!dma_done_o) begin
      @(negedge clk);
    end
    check_flag("dma_idle_o", 1'b1, dma_idle_o);
    @(negedge clk);
    // Done is a single cycle pulse
    check_flag("dma_done_o", 1'b0, dma_done_o);
    check_flag("dma_idle_o", 1'b1, dma_idle_o);
    for (int k = 0; k < int'(tbl[i].len); k++) begin
      ref_mem[tcdm_addr_t'(int'(tbl[i].dst) + k)] = ref_mem[tcdm_addr_t'(int'(tbl[i].addr) + k)];
    end
    @(posedge clk);
  endtask

  // A port without a request in flight must never see a response
  initial begin
    forever begin
      @(negedge clk);
      if (!rst_i) begin
        for (int p = 0; p < num_ports; p++) begin
          if (!pending[p]) begin
            check_flag($sformatf("core_resp_valid_o[%0d]", p), 1'b0, core_resp_valid_o[p]);
          end
        end
      end
    end
  end

  initial begin
    repeat (num_entries * 200) @(posedge clk);
    $display("Timeout after %0d cycles, a handshake never completed", num_entries * 200);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int i;
    int last;
    void'($urandom(37203));
    data_errors       = 0;
    flag_errors       = 0;
    pending           = '0;
    rst_i             = 1'b1;
    core_req_valid_i  = '0;
    core_req_i        = '0;
    core_resp_ready_i = '0;
    dma_valid_i       = 1'b0;
    dma_src_i         = '0;
    dma_dst_i         = '0;
    dma_len_i         = '0;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = '0;
    end
    load_table();
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    @(negedge clk);
    for (int p = 0; p < num_ports; p++) begin
      check_flag($sformatf("core_resp_valid_o[%0d]", p), 1'b0, core_resp_valid_o[p]);
    end
    check_flag("dma_idle_o", 1'b1, dma_idle_o);
    check_flag("dma_done_o", 1'b0, dma_done_o);
    @(posedge clk);
    i = 0;
    while (i < num_entries) begin
      if (tbl[i].dma) begin
        run_copy(i);
        i++;
      end else begin
        last = i;
        while (tbl[last].par && last + 1 < num_entries) begin
          last++;
        end
        fork
          run_port(0, i, last);
          run_port(1, i, last);
          run_port(2, i, last);
          run_port(3, i, last);
        join
        i = last + 1;
      end
    end
    repeat (3) @(posedge clk);
    $display("Checks done: %0d data mismatches, %0d flag mismatches", data_errors, flag_errors);
    if (data_errors + flag_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src/tcdm_sub_group.sv ====
/* TCDM sub-group: core ports and a copy DMA on a shared local interconnect.
   The DMA is initiator TCDM_NUM_PORTS; each initiator keeps one request in flight. */

`include "tcdm_config.svh"

module tcdm_sub_group (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // Core ports
  input  logic                 [`TCDM_NUM_PORTS-1:0]       core_req_valid_i,
  output logic                 [`TCDM_NUM_PORTS-1:0]       core_req_ready_o,
  input  tcdm_pkg::tcdm_req_t  [`TCDM_NUM_PORTS-1:0]       core_req_i,
  output logic                 [`TCDM_NUM_PORTS-1:0]       core_resp_valid_o,
  input  logic                 [`TCDM_NUM_PORTS-1:0]       core_resp_ready_i,
  output tcdm_pkg::tcdm_data_t [`TCDM_NUM_PORTS-1:0]       core_resp_rdata_o,
  // DMA
  input  logic                                             dma_valid_i,
  output logic                                             dma_ready_o,
  input  tcdm_pkg::tcdm_addr_t                             dma_src_i,
  input  tcdm_pkg::tcdm_addr_t                             dma_dst_i,
  input  logic                 [6:0]                       dma_len_i,
  output logic                                             dma_idle_o,
  output logic                                             dma_done_o
);

  import tcdm_pkg::*;

  localparam int unsigned dma_idx = `TCDM_NUM_PORTS;

  logic       [num_initiators-1:0] ini_req_valid;
  logic       [num_initiators-1:0] ini_req_ready;
  tcdm_req_t  [num_initiators-1:0] ini_req;
  logic       [num_initiators-1:0] ini_resp_valid;
  logic       [num_initiators-1:0] ini_resp_ready;
  tcdm_data_t [num_initiators-1:0] ini_resp_rdata;

  logic       dma_req_valid;
  tcdm_req_t  dma_req;
  logic       dma_resp_ready;
  logic       beat_load;
  logic       beat_step;
  logic       beat_last;
  logic       beat_zero;
  tcdm_addr_t beat_offset;

  // ------------------------------------------------------------
  // Initiator map, DMA on the top index
  // ------------------------------------------------------------

  assign ini_req_valid     = {dma_req_valid, core_req_valid_i};
  assign ini_req           = {dma_req, core_req_i};
  assign ini_resp_ready    = {dma_resp_ready, core_resp_ready_i};
  assign core_req_ready_o  = ini_req_ready[dma_idx-1:0];
  assign core_resp_valid_o = ini_resp_valid[dma_idx-1:0];
  assign core_resp_rdata_o = ini_resp_rdata[dma_idx-1:0];

  tcdm_local_interco i_local_interco (
    .clk_i           (clk_i         ),
    .rst_i           (rst_i         ),
    .ini_req_valid_i (ini_req_valid ),
    .ini_req_ready_o (ini_req_ready ),
    .ini_req_i       (ini_req       ),
    .ini_resp_valid_o(ini_resp_valid),
    .ini_resp_ready_i(ini_resp_ready),
    .ini_resp_rdata_o(ini_resp_rdata)
  );

  dma_ctrl_fsm i_dma_fsm (
    .clk_i           (clk_i                  ),
    .rst_i           (rst_i                  ),
    .dma_valid_i     (dma_valid_i            ),
    .dma_ready_o     (dma_ready_o            ),
    .dma_src_i       (dma_src_i              ),
    .dma_dst_i       (dma_dst_i              ),
    .beat_last_i     (beat_last              ),
    .beat_zero_i     (beat_zero              ),
    .beat_offset_i   (beat_offset            ),
    .beat_load_o     (beat_load              ),
    .beat_step_o     (beat_step              ),
    .mem_req_valid_o (dma_req_valid          ),
    .mem_req_ready_i (ini_req_ready[dma_idx] ),
    .mem_req_o       (dma_req                ),
    .mem_resp_valid_i(ini_resp_valid[dma_idx]),
    .mem_resp_ready_o(dma_resp_ready         ),
    .mem_resp_rdata_i(ini_resp_rdata[dma_idx]),
    .idle_o          (dma_idle_o             ),
    .done_o          (dma_done_o             )
  );

  dma_beat_counter i_dma_beats (
    .clk_i   (clk_i      ),
    .rst_i   (rst_i      ),
    .load_i  (beat_load  ),
    .len_i   (dma_len_i  ),
    .step_i  (beat_step  ),
    .offset_o(beat_offset),
    .last_o  (beat_last  ),
    .zero_o  (beat_zero  )
  );

endmodule
